// File: hw/spu_decode_pkg.sv
package spu_decode_pkg;

	localparam int instr_w    = 32;
	localparam int reg_addr_w = 7;	// 128 registers
	localparam int imm7_w     = 7;
	localparam int imm10_w    = 10;
	localparam int imm16_w    = 16;
	localparam int imm18_w    = 18;

	typedef logic [instr_w-1:0]    instr_word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [imm7_w-1:0]     imm7_t;
	typedef logic [imm10_w-1:0]    imm10_t;
	typedef logic [imm16_w-1:0]    imm16_t;
	typedef logic [imm18_w-1:0]    imm18_t;

	// operand format, picks which fields the unpacker pulls out
	typedef enum logic [2:0] {
		fmt_none = 3'd0,	// no opcode matched
		fmt_rrr  = 3'd1,	// rt, rb, ra, rc
		fmt_ri18 = 3'd2,	// rt + imm18
		fmt_ri10 = 3'd3,	// rt, ra + imm10
		fmt_ri16 = 3'd4,	// rt + imm16
		fmt_rr   = 3'd5,	// rt, ra, rb
		fmt_ri7  = 3'd6,	// rt, ra + shift count
		fmt_r1   = 3'd7	// rt, ra
	} op_fmt_t;

	typedef struct packed {
		logic      valid;
		logic      known;
		op_fmt_t   fmt;
		logic      use_ra;
		logic      use_rb;
		logic      use_rc;
		reg_addr_t rt;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rc;
		imm7_t     imm7;
		imm10_t    imm10;
		imm16_t    imm16;
		imm18_t    imm18;
	} decoded_t;

	// 4-bit opcodes, bits 3..0
	localparam logic [3:0] op_mpya = 4'b1100;	// multiply and add
	localparam logic [3:0] op_fma  = 4'b1110;	// floating multiply and add
	localparam logic [3:0] op_fms  = 4'b1111;	// floating multiply and subtract

	// 7-bit opcodes, bits 6..0
	localparam logic [6:0] op_ila = 7'b0100001;	// immediate load address

	// 8-bit opcodes, bits 7..0
	localparam logic [7:0] op_ahi    = 8'b00011101;	// add halfword imm
	localparam logic [7:0] op_ai     = 8'b00011100;	// add word imm
	localparam logic [7:0] op_sfhi   = 8'b00001101;	// subtract from halfword imm
	localparam logic [7:0] op_sfi    = 8'b00001100;	// subtract from word imm
	localparam logic [7:0] op_andhi  = 8'b00010101;
	localparam logic [7:0] op_andi   = 8'b00010100;
	localparam logic [7:0] op_orhi   = 8'b00000101;
	localparam logic [7:0] op_ori    = 8'b00000100;
	localparam logic [7:0] op_xorhi  = 8'b01000101;
	localparam logic [7:0] op_xori   = 8'b01000100;
	localparam logic [7:0] op_ceqhi  = 8'b01111101;	// compare equal
	localparam logic [7:0] op_ceqi   = 8'b01111100;
	localparam logic [7:0] op_cgthi  = 8'b01001101;	// compare greater than
	localparam logic [7:0] op_cgti   = 8'b01001100;
	localparam logic [7:0] op_clgthi = 8'b01011101;	// compare logical greater than
	localparam logic [7:0] op_clgti  = 8'b01011100;
	localparam logic [7:0] op_andbi  = 8'b00010110;	// and byte imm
	localparam logic [7:0] op_mpyi   = 8'b01110100;
	localparam logic [7:0] op_mpyui  = 8'b01110101;
	localparam logic [7:0] op_ceqbi  = 8'b01111110;	// compare equal byte imm

	// 9-bit opcodes, bits 8..0
	localparam logic [8:0] op_ilh  = 9'b010000011;	// immediate load halfword
	localparam logic [8:0] op_ilhu = 9'b010000010;	// immediate load halfword upper
	localparam logic [8:0] op_il   = 9'b010000001;	// immediate load word
	localparam logic [8:0] op_iohl = 9'b011000001;	// immediate or halfword lower

	// 11-bit opcodes with two source registers
	localparam logic [10:0] op_ah    = 11'b00011001000;	// add halfword
	localparam logic [10:0] op_a     = 11'b00011000000;	// add word
	localparam logic [10:0] op_sfh   = 11'b00001001000;
	localparam logic [10:0] op_sf    = 11'b00001000000;
	localparam logic [10:0] op_cg    = 11'b00011000010;	// carry generate
	localparam logic [10:0] op_and   = 11'b00011000001;
	localparam logic [10:0] op_andc  = 11'b01011000001;	// and with complement
	localparam logic [10:0] op_or    = 11'b00001000001;
	localparam logic [10:0] op_orc   = 11'b01011001001;
	localparam logic [10:0] op_xor   = 11'b01001000001;
	localparam logic [10:0] op_nand  = 11'b00011001001;
	localparam logic [10:0] op_nor   = 11'b00001001001;
	localparam logic [10:0] op_ceqh  = 11'b01111001000;
	localparam logic [10:0] op_ceq   = 11'b01111000000;
	localparam logic [10:0] op_cgth  = 11'b01001001000;
	localparam logic [10:0] op_cgt   = 11'b01001000000;
	localparam logic [10:0] op_clgth = 11'b01011001000;
	localparam logic [10:0] op_clgt  = 11'b01011000000;
	localparam logic [10:0] op_shlh  = 11'b00001011111;	// shift left halfword
	localparam logic [10:0] op_shl   = 11'b00001011011;
	localparam logic [10:0] op_roth  = 11'b00001011100;	// rotate halfword
	localparam logic [10:0] op_rot   = 11'b00001011000;
	localparam logic [10:0] op_mpy   = 11'b01111000100;
	localparam logic [10:0] op_mpyu  = 11'b01111001100;
	localparam logic [10:0] op_fa    = 11'b01011000100;	// floating add
	localparam logic [10:0] op_fs    = 11'b01011000101;
	localparam logic [10:0] op_fm    = 11'b01011000110;
	localparam logic [10:0] op_avgb  = 11'b00011010011;	// average bytes
	localparam logic [10:0] op_absdb = 11'b00001010011;	// abs differences of bytes
	localparam logic [10:0] op_sumb  = 11'b01001010011;	// sum bytes into halfwords
	localparam logic [10:0] op_ceqb  = 11'b01111010000;

	// 11-bit shift and rotate immediates, count in bits 17..11
	localparam logic [10:0] op_shlhi = 11'b00001111111;
	localparam logic [10:0] op_shli  = 11'b00001111011;
	localparam logic [10:0] op_rothi = 11'b00001111100;
	localparam logic [10:0] op_roti  = 11'b00001111000;

	// 11-bit single source ops
	localparam logic [10:0] op_clz  = 11'b01010100101;	// count leading zeros
	localparam logic [10:0] op_cntb = 11'b01010110100;	// count ones in bytes

endpackage

// File: hw/spu_opcode_matcher.sv
`timescale 1ns/1ns

module spu_opcode_matcher import spu_decode_pkg::*; (
	input  instr_word_t instr,
	output op_fmt_t     fmt
);

	op_fmt_t fmt4;
	op_fmt_t fmt7;
	op_fmt_t fmt8;
	op_fmt_t fmt9;
	op_fmt_t fmt11;

	// 4-bit group, multiply-add family
	always_comb begin
		case (instr[3:0])
			op_mpya,
			op_fma,
			op_fms:  fmt4 = fmt_rrr;
			default: fmt4 = fmt_none;
		endcase
	end

	always_comb begin
		case (instr[6:0])
			op_ila:  fmt7 = fmt_ri18;
			default: fmt7 = fmt_none;
		endcase
	end

	// 8-bit group, all 10-bit immediates
	always_comb begin
		case (instr[7:0])
			op_ahi,
			op_ai,
			op_sfhi,
			op_sfi,
			op_andhi,
			op_andi,
			op_orhi,
			op_ori,
			op_xorhi,
			op_xori,
			op_ceqhi,
			op_ceqi,
			op_cgthi,
			op_cgti,
			op_clgthi,
			op_clgti,
			op_andbi,
			op_mpyi,
			op_mpyui,
			op_ceqbi: fmt8 = fmt_ri10;
			default:  fmt8 = fmt_none;
		endcase
	end

	// 9-bit group, immediate loads
	always_comb begin
		case (instr[8:0])
			op_ilh,
			op_ilhu,
			op_il,
			op_iohl: fmt9 = fmt_ri16;
			default: fmt9 = fmt_none;
		endcase
	end

	// 11-bit group, mixed formats
	always_comb begin
		case (instr[10:0])
			op_ah,
			op_a,
			op_sfh,
			op_sf,
			op_cg,
			op_and,
			op_andc,
			op_or,
			op_orc,
			op_xor,
			op_nand,
			op_nor,
			op_ceqh,
			op_ceq,
			op_cgth,
			op_cgt,
			op_clgth,
			op_clgt,
			op_shlh,
			op_shl,
			op_roth,
			op_rot,
			op_mpy,
			op_mpyu,
			op_fa,
			op_fs,
			op_fm,
			op_avgb,
			op_absdb,
			op_sumb,
			op_ceqb:  fmt11 = fmt_rr;
			op_shlhi,
			op_shli,
			op_rothi,
			op_roti:  fmt11 = fmt_ri7;	// count sits where rb would
			op_clz,
			op_cntb:  fmt11 = fmt_r1;
			default:  fmt11 = fmt_none;
		endcase
	end

	// shortest opcode wins
	always_comb begin
		if (fmt4 != fmt_none) begin
			fmt = fmt4;
		end else if (fmt7 != fmt_none) begin
			fmt = fmt7;
		end else if (fmt8 != fmt_none) begin
			fmt = fmt8;
		end else if (fmt9 != fmt_none) begin
			fmt = fmt9;
		end else begin
			fmt = fmt11;	// fmt_none if nothing hit
		end
	end

endmodule

// File: hw/spu_operand_unpack.sv
`timescale 1ns/1ns

module spu_operand_unpack import spu_decode_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_valid,
	input  instr_word_t instr,
	input  op_fmt_t     fmt,
	output decoded_t    dec
);

	decoded_t dec_nxt;

	always_comb begin
		dec_nxt = '0;	// unused fields stay zero
		if (instr_valid) begin
			dec_nxt.valid = 1'b1;
			dec_nxt.known = (fmt != fmt_none);
			dec_nxt.fmt   = fmt;
			case (fmt)
				fmt_rrr: begin
					// rt lives low in this format
					dec_nxt.rt     = instr[10:4];
					dec_nxt.rb     = instr[17:11];
					dec_nxt.ra     = instr[24:18];
					dec_nxt.rc     = instr[31:25];
					dec_nxt.use_ra = 1'b1;
					dec_nxt.use_rb = 1'b1;
					dec_nxt.use_rc = 1'b1;
				end
				fmt_ri18: begin
					dec_nxt.imm18 = instr[24:7];
					dec_nxt.rt    = instr[31:25];
				end
				fmt_ri10: begin
					dec_nxt.imm10  = instr[17:8];
					dec_nxt.ra     = instr[24:18];
					dec_nxt.rt     = instr[31:25];
					dec_nxt.use_ra = 1'b1;
				end
				fmt_ri16: begin
					dec_nxt.imm16 = instr[24:9];
					dec_nxt.rt    = instr[31:25];
				end
				fmt_rr: begin
					dec_nxt.rb     = instr[17:11];
					dec_nxt.ra     = instr[24:18];
					dec_nxt.rt     = instr[31:25];
					dec_nxt.use_ra = 1'b1;
					dec_nxt.use_rb = 1'b1;
				end
				fmt_ri7: begin
					dec_nxt.imm7   = instr[17:11];	// shift / rotate count
					dec_nxt.ra     = instr[24:18];
					dec_nxt.rt     = instr[31:25];
					dec_nxt.use_ra = 1'b1;
				end
				fmt_r1: begin
					dec_nxt.ra     = instr[24:18];
					dec_nxt.rt     = instr[31:25];
					dec_nxt.use_ra = 1'b1;
				end
				default: begin
					// unknown word, only valid is reported
				end
			endcase
		end
	end

	// decode / register fetch boundary
	always_ff @(posedge clk) begin
		if (reset) begin
			dec <= '0;
		end else begin
			dec <= dec_nxt;
		end
	end

endmodule

// File: hw/spu_instr_decoder.sv
`timescale 1ns/1ns

module spu_instr_decoder import spu_decode_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_valid,
	input  instr_word_t instr,
	output decoded_t    dec
);

	op_fmt_t fmt;	// combinational match result

	spu_opcode_matcher u_matcher (
		.instr (instr),
		.fmt   (fmt)
	);

	// field split and output register
	spu_operand_unpack u_unpack (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.fmt         (fmt),
		.dec         (dec)
	);

endmodule

// File: dv/spu_decoder_props.sv
`timescale 1ns/1ns

module spu_decoder_props import spu_decode_pkg::*; (
	input logic     clk,
	input logic     reset,
	input decoded_t dec
);

	int fails = 0;	// summed into the final count

	// output register clears one cycle after reset
	a_reset_clears: assert property (@(posedge clk) reset |=> dec == '0)
		else begin
			fails++;
			$error("dec was not cleared in the cycle after reset");
		end

	a_rc_only_rrr: assert property (@(posedge clk) disable iff (reset)
		dec.use_rc |-> dec.fmt == fmt_rrr)
		else begin
			fails++;
			$error("use_rc set outside the rrr format");
		end

	// idle slot carries nothing
	a_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!dec.valid |-> dec == '0)
		else begin
			fails++;
			$error("dec has bits set while valid is low");
		end

endmodule

bind spu_instr_decoder spu_decoder_props u_props (
	.clk   (clk),
	.reset (reset),
	.dec   (dec)
);

// File: dv/spu_decoder_checker.sv
`timescale 1ns/1ns

module spu_decoder_checker import spu_decode_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_valid,
	input  instr_word_t instr,
	input  decoded_t    dec,
	output int          errors,
	output int          checks,
	output int          valid_checks
);

	logic [10:0] tbl_code [0:79];	// opcode, right aligned
	int          tbl_len [0:79];
	op_fmt_t     tbl_fmt [0:79];
	int          n_ops = 0;
	decoded_t    exp_q [$];
	int          err_count = 0;
	int          chk_count = 0;
	int          vld_count = 0;

	assign errors       = err_count;
	assign checks       = chk_count;
	assign valid_checks = vld_count;

	task automatic add_op(input op_fmt_t f, input int len, input logic [10:0] code);
		tbl_fmt[n_ops]  = f;
		tbl_len[n_ops]  = len;
		tbl_code[n_ops] = code;
		n_ops++;
	endtask

	initial begin
		add_op(fmt_rrr, 4, 11'b1100);
		add_op(fmt_rrr, 4, 11'b1110);
		add_op(fmt_rrr, 4, 11'b1111);
		add_op(fmt_ri18, 7, 11'b0100001);
		add_op(fmt_ri10, 8, 11'b00011101);
		add_op(fmt_ri10, 8, 11'b00011100);
		add_op(fmt_ri10, 8, 11'b00001101);
		add_op(fmt_ri10, 8, 11'b00001100);
		add_op(fmt_ri10, 8, 11'b00010101);
		add_op(fmt_ri10, 8, 11'b00010100);
		add_op(fmt_ri10, 8, 11'b00000101);
		add_op(fmt_ri10, 8, 11'b00000100);
		add_op(fmt_ri10, 8, 11'b01000101);
		add_op(fmt_ri10, 8, 11'b01000100);
		add_op(fmt_ri10, 8, 11'b01111101);
		add_op(fmt_ri10, 8, 11'b01111100);
		add_op(fmt_ri10, 8, 11'b01001101);
		add_op(fmt_ri10, 8, 11'b01001100);
		add_op(fmt_ri10, 8, 11'b01011101);
		add_op(fmt_ri10, 8, 11'b01011100);
		add_op(fmt_ri10, 8, 11'b00010110);
		add_op(fmt_ri10, 8, 11'b01110100);
		add_op(fmt_ri10, 8, 11'b01110101);
		add_op(fmt_ri10, 8, 11'b01111110);
		add_op(fmt_ri16, 9, 11'b010000011);
		add_op(fmt_ri16, 9, 11'b010000010);
		add_op(fmt_ri16, 9, 11'b010000001);
		add_op(fmt_ri16, 9, 11'b011000001);
		add_op(fmt_rr, 11, 11'b00011001000);
		add_op(fmt_rr, 11, 11'b00011000000);
		add_op(fmt_rr, 11, 11'b00001001000);
		add_op(fmt_rr, 11, 11'b00001000000);
		add_op(fmt_rr, 11, 11'b00011000010);
		add_op(fmt_rr, 11, 11'b00011000001);
		add_op(fmt_rr, 11, 11'b01011000001);
		add_op(fmt_rr, 11, 11'b00001000001);
		add_op(fmt_rr, 11, 11'b01011001001);
		add_op(fmt_rr, 11, 11'b01001000001);
		add_op(fmt_rr, 11, 11'b00011001001);
		add_op(fmt_rr, 11, 11'b00001001001);
		add_op(fmt_rr, 11, 11'b01111001000);
		add_op(fmt_rr, 11, 11'b01111000000);
		add_op(fmt_rr, 11, 11'b01001001000);
		add_op(fmt_rr, 11, 11'b01001000000);
		add_op(fmt_rr, 11, 11'b01011001000);
		add_op(fmt_rr, 11, 11'b01011000000);
		add_op(fmt_rr, 11, 11'b00001011111);
		add_op(fmt_rr, 11, 11'b00001011011);
		add_op(fmt_rr, 11, 11'b00001011100);
		add_op(fmt_rr, 11, 11'b00001011000);
		add_op(fmt_rr, 11, 11'b01111000100);
		add_op(fmt_rr, 11, 11'b01111001100);
		add_op(fmt_rr, 11, 11'b01011000100);
		add_op(fmt_rr, 11, 11'b01011000101);
		add_op(fmt_rr, 11, 11'b01011000110);
		add_op(fmt_rr, 11, 11'b00011010011);
		add_op(fmt_rr, 11, 11'b00001010011);
		add_op(fmt_rr, 11, 11'b01001010011);
		add_op(fmt_rr, 11, 11'b01111010000);
		add_op(fmt_ri7, 11, 11'b00001111111);	// shift / rotate immediates
		add_op(fmt_ri7, 11, 11'b00001111011);
		add_op(fmt_ri7, 11, 11'b00001111100);
		add_op(fmt_ri7, 11, 11'b00001111000);
		add_op(fmt_r1, 11, 11'b01010100101);	// clz
		add_op(fmt_r1, 11, 11'b01010110100);	// cntb
	end

	// reference model, shortest matching opcode decides the format
	function automatic decoded_t model_decode(input logic valid, input instr_word_t w);
		decoded_t    d;
		op_fmt_t     f;
		logic [31:0] mask;
		int          len;
		int          k;
		d = '0;
		f = fmt_none;
		if (!valid) begin
			return d;
		end
		for (len = 1; len <= 11; len++) begin
			mask = (32'd1 << len) - 1;
			for (k = 0; k < n_ops; k++) begin
				if (f == fmt_none && tbl_len[k] == len && (w & mask) == {21'd0, tbl_code[k]}) begin
					f = tbl_fmt[k];
				end
			end
		end
		d.valid = 1'b1;
		d.known = (f != fmt_none);
		d.fmt   = f;
		if (f != fmt_none) begin
			d.use_ra = (f != fmt_ri18) && (f != fmt_ri16);
			d.use_rb = (f == fmt_rrr) || (f == fmt_rr);
			d.use_rc = (f == fmt_rrr);
			d.rt     = (f == fmt_rrr) ? w[10:4] : w[31:25];
			d.ra     = d.use_ra ? w[24:18] : '0;
			d.rb     = d.use_rb ? w[17:11] : '0;
			d.rc     = d.use_rc ? w[31:25] : '0;
			d.imm7   = (f == fmt_ri7) ? w[17:11] : '0;
			d.imm10  = (f == fmt_ri10) ? w[17:8] : '0;
			d.imm16  = (f == fmt_ri16) ? w[24:9] : '0;
			d.imm18  = (f == fmt_ri18) ? w[24:7] : '0;
		end
		return d;
	endfunction

	// expectation for each edge is compared one edge later
	always @(posedge clk) begin
		decoded_t want;
		if (exp_q.size() > 0) begin
			want = exp_q.pop_front();
			chk_count++;
			if (want.valid) begin
				vld_count++;
			end
			if (dec !== want) begin
				err_count++;
				$display("error at %0t ns: dec expected %h got %h", $time, want, dec);
			end
		end
		if (reset) begin
			exp_q.push_back('0);
		end else begin
			exp_q.push_back(model_decode(instr_valid, instr));
		end
	end

endmodule

// File: dv/spu_decoder_tb.sv
`timescale 1ns/1ns

module spu_decoder_tb import spu_decode_pkg::*; ();

	logic        clk;
	logic        reset;
	logic        instr_valid;
	instr_word_t instr;
	decoded_t    dec;
	int          errors;
	int          checks;
	int          valid_checks;
	int          valid_sent;
	int          wait_cycles;

	always #10 clk = ~clk;	// 20 ns period

	spu_instr_decoder i_dut (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dec         (dec)
	);

	spu_decoder_checker i_checker (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.dec          (dec),
		.errors       (errors),
		.checks       (checks),
		.valid_checks (valid_checks)
	);

	// random upper bits, opcode in the low bits
	function automatic instr_word_t place_opcode(input instr_word_t rnd, input int len,
			input logic [10:0] code);
		instr_word_t mask;
		mask = (32'd1 << len) - 1;
		return (rnd & ~mask) | ({21'd0, code} & mask);
	endfunction

	task automatic send_word(input instr_word_t w);
		if ($urandom_range(3) == 0) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			instr       <= $urandom;	// junk on an idle bus
		end
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= w;
		valid_sent++;
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		reset       <= 1'b1;
		instr_valid <= 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		valid_sent  = 0;
		void'($urandom(98));
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (int k = 0; k < i_checker.n_ops; k++) begin
			send_word(place_opcode($urandom, i_checker.tbl_len[k], i_checker.tbl_code[k]));
		end
		pulse_reset();
		repeat (400) begin
			send_word($urandom);
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		wait_cycles = 0;
		while (valid_checks < valid_sent && wait_cycles < 50) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (valid_checks < valid_sent) begin
			$display("timeout: %0d valid words never reached the output",
				valid_sent - valid_checks);
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			repeat (2) @(negedge clk);
			$display("checks %0d, valid words %0d, errors %0d, assertion failures %0d",
				checks, valid_checks, errors, i_dut.u_props.fails);
			if (errors == 0 && i_dut.u_props.fails == 0 && checks > 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

endmodule

// File: src.f
hw/spu_decode_pkg.sv
hw/spu_opcode_matcher.sv
hw/spu_operand_unpack.sv
hw/spu_instr_decoder.sv
dv/spu_decoder_props.sv
dv/spu_decoder_checker.sv
dv/spu_decoder_tb.sv

// File: Bender.yml
package:
  name: spu_instr_decoder

sources:
  - files:
      - hw/spu_decode_pkg.sv
      - hw/spu_opcode_matcher.sv
      - hw/spu_operand_unpack.sv
      - hw/spu_instr_decoder.sv
  - target: simulation
    files:
      - dv/spu_decoder_props.sv
      - dv/spu_decoder_checker.sv
      - dv/spu_decoder_tb.sv
